/* include/dual_issue_backend_params.svh */
`ifndef DUAL_ISSUE_BACKEND_PARAMS_SVH
`define DUAL_ISSUE_BACKEND_PARAMS_SVH

// data path and pc width
`define DIB_XLEN 32

// architectural register count and the matching address width
`define DIB_NREGS 32
`define DIB_REG_AW 5

`endif

/* rtl/dual_issue_backend_pkg.sv */
`include "dual_issue_backend_params.svh"

package dual_issue_backend_pkg;

    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_AND = 4'd3,
        OP_OR  = 4'd4,
        OP_XOR = 4'd5,
        OP_SLL = 4'd6,
        OP_SRL = 4'd7,
        OP_SLT = 4'd8,
        OP_LUI = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        EXC_NONE    = 2'd0,
        EXC_SYSCALL = 2'd1,
        EXC_BREAK   = 2'd2,
        EXC_PRIV    = 2'd3
    } exc_code_e;

    // one decoded instruction as delivered by the decoder
    typedef struct packed {
        logic                   valid;
        logic [`DIB_XLEN-1:0]   pc;
        logic [`DIB_XLEN-1:0]   inst;
        alu_op_e                uop;
        logic                   use_imm;
        logic [`DIB_XLEN-1:0]   imm;
        logic [`DIB_REG_AW-1:0] rj;
        logic [`DIB_REG_AW-1:0] rk;
        logic [`DIB_REG_AW-1:0] rd;
        logic                   we;
        logic                   is_syscall;
        logic                   is_break;
        logic                   is_priv;
    } slot_t;

    typedef struct packed {
        slot_t slot0;
        slot_t slot1;
    } issue_pair_t;

    typedef struct packed {
        slot_t                ins;
        logic [`DIB_XLEN-1:0] rj_data;
        logic [`DIB_XLEN-1:0] rk_data;
    } ex_slot_t;

    typedef struct packed {
        ex_slot_t slot0;
        ex_slot_t slot1;
    } ex_pair_t;

    typedef struct packed {
        logic                   we;
        logic [`DIB_REG_AW-1:0] addr;
        logic [`DIB_XLEN-1:0]   data;
    } wb_port_t;

    typedef struct packed {
        logic                   valid;
        logic [`DIB_XLEN-1:0]   pc;
        logic [`DIB_REG_AW-1:0] rd;
        logic                   we;
        logic [`DIB_XLEN-1:0]   result;
        exc_code_e              exc;
    } commit_slot_t;

    typedef struct packed {
        commit_slot_t slot0;
        commit_slot_t slot1;
    } commit_pair_t;

endpackage

/* rtl/regfile.sv */
`timescale 1ns/10ps
`include "dual_issue_backend_params.svh"

module regfile (
    input  logic                             clk,
    input  logic                             arst_n,
    input  dual_issue_backend_pkg::wb_port_t wr0,
    input  dual_issue_backend_pkg::wb_port_t wr1,
    input  logic [`DIB_REG_AW-1:0]           raddr0,
    input  logic [`DIB_REG_AW-1:0]           raddr1,
    input  logic [`DIB_REG_AW-1:0]           raddr2,
    input  logic [`DIB_REG_AW-1:0]           raddr3,
    output logic [`DIB_XLEN-1:0]             rdata0,
    output logic [`DIB_XLEN-1:0]             rdata1,
    output logic [`DIB_XLEN-1:0]             rdata2,
    output logic [`DIB_XLEN-1:0]             rdata3
);

    logic [`DIB_XLEN-1:0]   regs  [`DIB_NREGS];
    logic [`DIB_REG_AW-1:0] raddr [4];
    logic [`DIB_XLEN-1:0]   rdata [4];

    assign raddr[0] = raddr0;
    assign raddr[1] = raddr1;
    assign raddr[2] = raddr2;
    assign raddr[3] = raddr3;

    assign rdata0 = rdata[0];
    assign rdata1 = rdata[1];
    assign rdata2 = rdata[2];
    assign rdata3 = rdata[3];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `DIB_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // r0 is never written, and wr1 lands last so it wins on a shared address
            if (wr0.we && (wr0.addr != '0)) begin
                regs[wr0.addr] <= wr0.data;
            end
            if (wr1.we && (wr1.addr != '0)) begin
                regs[wr1.addr] <= wr1.data;
            end
        end
    end

    // write-first read, same priority as the write side
    for (genvar p = 0; p < 4; p++) begin : g_read
        always_comb begin
            if (wr1.we && (wr1.addr != '0) && (wr1.addr == raddr[p])) begin
                rdata[p] = wr1.data;
            end else if (wr0.we && (wr0.addr != '0) && (wr0.addr == raddr[p])) begin
                rdata[p] = wr0.data;
            end else begin
                rdata[p] = regs[raddr[p]];
            end
        end
    end

endmodule

/* rtl/reg_read_stage.sv */
`timescale 1ns/10ps
`include "dual_issue_backend_params.svh"

module reg_read_stage (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                flush,
    input  logic                                id_valid,
    input  dual_issue_backend_pkg::issue_pair_t id_pair,
    input  logic                                ex_allowin,
    input  dual_issue_backend_pkg::wb_port_t    wr0,
    input  dual_issue_backend_pkg::wb_port_t    wr1,
    output logic                                id_ready,
    output dual_issue_backend_pkg::ex_pair_t    rr_pair
);

    logic [`DIB_XLEN-1:0]             rj0_data;
    logic [`DIB_XLEN-1:0]             rk0_data;
    logic [`DIB_XLEN-1:0]             rj1_data;
    logic [`DIB_XLEN-1:0]             rk1_data;
    dual_issue_backend_pkg::ex_pair_t rr_next;

    regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .wr0    (wr0),
        .wr1    (wr1),
        .raddr0 (id_pair.slot0.rj),
        .raddr1 (id_pair.slot0.rk),
        .raddr2 (id_pair.slot1.rj),
        .raddr3 (id_pair.slot1.rk),
        .rdata0 (rj0_data),
        .rdata1 (rk0_data),
        .rdata2 (rj1_data),
        .rdata3 (rk1_data)
    );

    always_comb begin
        rr_next.slot0.ins     = id_pair.slot0;
        rr_next.slot0.rj_data = rj0_data;
        rr_next.slot0.rk_data = rk0_data;
        rr_next.slot1.ins     = id_pair.slot1;
        rr_next.slot1.rj_data = rj1_data;
        rr_next.slot1.rk_data = rk1_data;
    end

    // flush beats acceptance, and an empty decoder turns into a bubble when execute moves
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rr_pair <= '0;
        end else if (flush || (ex_allowin && !id_valid)) begin
            rr_pair <= '0;
        end else if (id_valid && ex_allowin) begin
            rr_pair <= rr_next;
        end
    end

    assign id_ready = ex_allowin;

endmodule

/* rtl/operand_bypass.sv */
`timescale 1ns/10ps
`include "dual_issue_backend_params.svh"

module operand_bypass (
    input  dual_issue_backend_pkg::ex_pair_t     rr_pair,
    input  dual_issue_backend_pkg::commit_pair_t wb_pair,
    input  logic [`DIB_XLEN-1:0]                 slot0_result,
    output logic [`DIB_XLEN-1:0]                 op0_a,
    output logic [`DIB_XLEN-1:0]                 op0_b,
    output logic [`DIB_XLEN-1:0]                 op1_a,
    output logic [`DIB_XLEN-1:0]                 op1_b
);

    logic slot0_writes;

    function automatic logic wb_hit(
        input dual_issue_backend_pkg::commit_slot_t p,
        input logic [`DIB_REG_AW-1:0]               src
    );
        return p.valid && p.we && (p.rd != '0) && (p.rd == src) &&
               (p.exc == dual_issue_backend_pkg::EXC_NONE);
    endfunction

    // writeback slot 1 is younger than slot 0, so it is checked first
    function automatic logic [`DIB_XLEN-1:0] from_wb(
        input logic [`DIB_REG_AW-1:0]               src,
        input logic [`DIB_XLEN-1:0]                 rf_data,
        input dual_issue_backend_pkg::commit_pair_t wb
    );
        if (wb_hit(wb.slot1, src)) begin
            return wb.slot1.result;
        end
        if (wb_hit(wb.slot0, src)) begin
            return wb.slot0.result;
        end
        return rf_data;
    endfunction

    // slot 0 only forwards if it will actually write, so trapping instructions are skipped
    assign slot0_writes = rr_pair.slot0.ins.valid && rr_pair.slot0.ins.we &&
                          (rr_pair.slot0.ins.rd != '0) &&
                          !(rr_pair.slot0.ins.is_syscall || rr_pair.slot0.ins.is_break ||
                            rr_pair.slot0.ins.is_priv);

    always_comb begin
        op0_a = from_wb(rr_pair.slot0.ins.rj, rr_pair.slot0.rj_data, wb_pair);
        op0_b = from_wb(rr_pair.slot0.ins.rk, rr_pair.slot0.rk_data, wb_pair);
        if (rr_pair.slot0.ins.use_imm) begin
            op0_b = rr_pair.slot0.ins.imm;
        end

        op1_a = from_wb(rr_pair.slot1.ins.rj, rr_pair.slot1.rj_data, wb_pair);
        if (slot0_writes && (rr_pair.slot0.ins.rd == rr_pair.slot1.ins.rj)) begin
            op1_a = slot0_result;
        end
        op1_b = from_wb(rr_pair.slot1.ins.rk, rr_pair.slot1.rk_data, wb_pair);
        if (slot0_writes && (rr_pair.slot0.ins.rd == rr_pair.slot1.ins.rk)) begin
            op1_b = slot0_result;
        end
        if (rr_pair.slot1.ins.use_imm) begin
            op1_b = rr_pair.slot1.ins.imm;
        end
    end

endmodule

/* rtl/alu.sv */
`timescale 1ns/10ps
`include "dual_issue_backend_params.svh"

module alu (
    input  dual_issue_backend_pkg::alu_op_e uop,
    input  logic [`DIB_XLEN-1:0]            a,
    input  logic [`DIB_XLEN-1:0]            b,
    output logic [`DIB_XLEN-1:0]            result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (uop)
            dual_issue_backend_pkg::OP_ADD: begin
                result = a + b;
            end
            dual_issue_backend_pkg::OP_SUB: begin
                result = a - b;
            end
            dual_issue_backend_pkg::OP_AND: begin
                result = a & b;
            end
            dual_issue_backend_pkg::OP_OR: begin
                result = a | b;
            end
            dual_issue_backend_pkg::OP_XOR: begin
                result = a ^ b;
            end
            dual_issue_backend_pkg::OP_SLL: begin
                result = a << shamt;
            end
            dual_issue_backend_pkg::OP_SRL: begin
                result = a >> shamt;
            end
            dual_issue_backend_pkg::OP_SLT: begin
                result = {{(`DIB_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            end
            // upper immediate comes in on b
            dual_issue_backend_pkg::OP_LUI: begin
                result = b << 12;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/10ps
`include "dual_issue_backend_params.svh"

module execute_stage (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 ex_hold,
    input  dual_issue_backend_pkg::ex_pair_t     rr_pair,
    output logic                                 ex_allowin,
    output dual_issue_backend_pkg::wb_port_t     wb0,
    output dual_issue_backend_pkg::wb_port_t     wb1,
    output dual_issue_backend_pkg::commit_pair_t commit
);

    logic [`DIB_XLEN-1:0]                 op0_a;
    logic [`DIB_XLEN-1:0]                 op0_b;
    logic [`DIB_XLEN-1:0]                 op1_a;
    logic [`DIB_XLEN-1:0]                 op1_b;
    logic [`DIB_XLEN-1:0]                 result0;
    logic [`DIB_XLEN-1:0]                 result1;
    dual_issue_backend_pkg::commit_pair_t wb_next;
    dual_issue_backend_pkg::commit_pair_t wb_pair;
    logic                                 fresh;

    // syscall first, then break, then privileged
    function automatic dual_issue_backend_pkg::exc_code_e exc_of(
        input dual_issue_backend_pkg::slot_t s
    );
        if (s.is_syscall) begin
            return dual_issue_backend_pkg::EXC_SYSCALL;
        end
        if (s.is_break) begin
            return dual_issue_backend_pkg::EXC_BREAK;
        end
        if (s.is_priv) begin
            return dual_issue_backend_pkg::EXC_PRIV;
        end
        return dual_issue_backend_pkg::EXC_NONE;
    endfunction

    function automatic dual_issue_backend_pkg::commit_slot_t to_commit(
        input dual_issue_backend_pkg::slot_t s,
        input logic [`DIB_XLEN-1:0]          res
    );
        dual_issue_backend_pkg::commit_slot_t c;
        c.valid  = s.valid;
        c.pc     = s.pc;
        c.rd     = s.rd;
        c.we     = s.we;
        c.result = res;
        c.exc    = exc_of(s);
        return c;
    endfunction

    // a trapping instruction reports its code but leaves the register file alone
    function automatic dual_issue_backend_pkg::wb_port_t to_port(
        input dual_issue_backend_pkg::commit_slot_t c
    );
        dual_issue_backend_pkg::wb_port_t w;
        w.we   = c.valid && c.we && (c.exc == dual_issue_backend_pkg::EXC_NONE);
        w.addr = c.rd;
        w.data = c.result;
        return w;
    endfunction

    assign ex_allowin = !ex_hold;

    operand_bypass u_bypass (
        .rr_pair      (rr_pair),
        .wb_pair      (wb_pair),
        .slot0_result (result0),
        .op0_a        (op0_a),
        .op0_b        (op0_b),
        .op1_a        (op1_a),
        .op1_b        (op1_b)
    );

    alu u_alu0 (
        .uop    (rr_pair.slot0.ins.uop),
        .a      (op0_a),
        .b      (op0_b),
        .result (result0)
    );

    alu u_alu1 (
        .uop    (rr_pair.slot1.ins.uop),
        .a      (op1_a),
        .b      (op1_b),
        .result (result1)
    );

    always_comb begin
        wb_next.slot0 = to_commit(rr_pair.slot0.ins, result0);
        wb_next.slot1 = to_commit(rr_pair.slot1.ins, result1);
    end

    // under hold the pair stays put for forwarding but only commits on its first cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_pair <= '0;
            fresh   <= 1'b0;
        end else if (ex_hold) begin
            fresh <= 1'b0;
        end else begin
            wb_pair <= wb_next;
            fresh   <= 1'b1;
        end
    end

    always_comb begin
        commit             = wb_pair;
        commit.slot0.valid = wb_pair.slot0.valid && fresh;
        commit.slot1.valid = wb_pair.slot1.valid && fresh;
    end

    assign wb0 = to_port(commit.slot0);
    assign wb1 = to_port(commit.slot1);

endmodule

/* rtl/dual_issue_backend.sv */
`timescale 1ns/10ps

module dual_issue_backend (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  logic                                 flush,
    input  logic                                 ex_hold,
    input  logic                                 id_valid,
    input  dual_issue_backend_pkg::issue_pair_t  id_pair,
    output logic                                 id_ready,
    output dual_issue_backend_pkg::commit_pair_t commit
);

    dual_issue_backend_pkg::ex_pair_t rr_pair;
    dual_issue_backend_pkg::wb_port_t wb0;
    dual_issue_backend_pkg::wb_port_t wb1;
    logic                             ex_allowin;

    reg_read_stage u_reg_read (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .id_valid   (id_valid),
        .id_pair    (id_pair),
        .ex_allowin (ex_allowin),
        .wr0        (wb0),
        .wr1        (wb1),
        .id_ready   (id_ready),
        .rr_pair    (rr_pair)
    );

    // writeback ports loop back into the register file inside the read stage
    execute_stage u_execute (
        .clk        (clk),
        .arst_n     (arst_n),
        .ex_hold    (ex_hold),
        .rr_pair    (rr_pair),
        .ex_allowin (ex_allowin),
        .wb0        (wb0),
        .wb1        (wb1),
        .commit     (commit)
    );

endmodule

/* dv/dual_issue_backend_tb.sv */
`timescale 1ns/10ps
`include "dual_issue_backend_params.svh"

module dual_issue_backend_tb;

    localparam int RESET_CYCLES  = 10;
    localparam int BASIC_CYCLES  = 24;
    localparam int RANDOM_CYCLES = 300;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + BASIC_CYCLES + 5 * RANDOM_CYCLES;
    localparam int CYCLE_LIMIT   = TOTAL_CYCLES * 3 / 2 + 100;

    logic                                 clk;
    logic                                 arst_n;
    logic                                 flush;
    logic                                 ex_hold;
    logic                                 id_valid;
    logic                                 id_ready;
    dual_issue_backend_pkg::issue_pair_t  id_pair;
    dual_issue_backend_pkg::commit_pair_t commit;

    logic [`DIB_XLEN-1:0]                 model_rf [`DIB_NREGS];
    dual_issue_backend_pkg::issue_pair_t  rr_model;
    logic                                 rr_full;
    dual_issue_backend_pkg::commit_pair_t expect_q [$];
    integer                               seed;
    int                                   err_count;
    int                                   check_count;
    int                                   cycle_count;
    logic [`DIB_REG_AW-1:0]               last_rd;
    logic [`DIB_XLEN-1:0]                 next_pc;

    dual_issue_backend u_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .ex_hold  (ex_hold),
        .id_valid (id_valid),
        .id_pair  (id_pair),
        .id_ready (id_ready),
        .commit   (commit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run passed the limit of %0d cycles and was stopped", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // in-order execution of one instruction against the model register file
    task automatic exec_slot(input dual_issue_backend_pkg::slot_t s,
                             output dual_issue_backend_pkg::commit_slot_t c);
        logic [`DIB_XLEN-1:0] a;
        logic [`DIB_XLEN-1:0] b;
        a = model_rf[s.rj];
        b = s.use_imm ? s.imm : model_rf[s.rk];
        case (s.uop)
            dual_issue_backend_pkg::OP_ADD: c.result = a + b;
            dual_issue_backend_pkg::OP_SUB: c.result = a - b;
            dual_issue_backend_pkg::OP_AND: c.result = a & b;
            dual_issue_backend_pkg::OP_OR:  c.result = a | b;
            dual_issue_backend_pkg::OP_XOR: c.result = a ^ b;
            dual_issue_backend_pkg::OP_SLL: c.result = a << b[4:0];
            dual_issue_backend_pkg::OP_SRL: c.result = a >> b[4:0];
            dual_issue_backend_pkg::OP_SLT: c.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            dual_issue_backend_pkg::OP_LUI: c.result = s.imm << 12;
            default: c.result = '0;
        endcase
        c.valid = s.valid;
        c.pc    = s.pc;
        c.rd    = s.rd;
        c.we    = s.we;
        if (s.is_syscall) c.exc = dual_issue_backend_pkg::EXC_SYSCALL;
        else if (s.is_break) c.exc = dual_issue_backend_pkg::EXC_BREAK;
        else if (s.is_priv) c.exc = dual_issue_backend_pkg::EXC_PRIV;
        else c.exc = dual_issue_backend_pkg::EXC_NONE;
        if (s.valid && s.we && (c.exc == dual_issue_backend_pkg::EXC_NONE) && (s.rd != '0)) begin
            model_rf[s.rd] = c.result;
        end
    endtask

    // a pair retires into the model on the edge where it leaves register read
    always @(posedge clk or negedge arst_n) begin
        dual_issue_backend_pkg::commit_pair_t cp;
        if (!arst_n) begin
            for (int i = 0; i < `DIB_NREGS; i++) begin
                model_rf[i] = '0;
            end
            rr_model = '0;
            rr_full  = 1'b0;
        end else if (!ex_hold) begin
            if (rr_full) begin
                exec_slot(rr_model.slot0, cp.slot0);
                exec_slot(rr_model.slot1, cp.slot1);
                expect_q.push_back(cp);
            end
            rr_model = id_pair;
            rr_full  = id_valid && !flush && (id_pair.slot0.valid || id_pair.slot1.valid);
        end else if (flush) begin
            rr_full = 1'b0;
        end
    end

    task automatic compare_commit_slot(input dual_issue_backend_pkg::commit_slot_t got,
                                       input dual_issue_backend_pkg::commit_slot_t want,
                                       input int slot);
        check_count++;
        if ((got.valid !== want.valid) || (want.valid && (got !== want))) begin
            err_count++;
            $display("Error at %0t: commit slot %0d got v%b pc %h rd %0d we %b res %h exc %0d",
                     $time, slot, got.valid, got.pc, got.rd, got.we, got.result, got.exc);
            $display("    expected v%b pc %h rd %0d we %b res %h exc %0d",
                     want.valid, want.pc, want.rd, want.we, want.result, want.exc);
        end
    endtask

    task automatic compare_ready(input logic got, input logic want);
        check_count++;
        if (got !== want) begin
            err_count++;
            $display("Error at %0t: id_ready is %b, expected %b", $time, got, want);
        end
    endtask

    task automatic check_outputs();
        dual_issue_backend_pkg::commit_pair_t want;
        if (expect_q.size() > 0) begin
            want = expect_q.pop_front();
            compare_commit_slot(commit.slot0, want.slot0, 0);
            compare_commit_slot(commit.slot1, want.slot1, 1);
        end else if (commit.slot0.valid || commit.slot1.valid) begin
            err_count++;
            $display("Commit at %0t with no pair in flight, so a pair was duplicated", $time);
        end
        compare_ready(id_ready, !ex_hold);
    endtask

    task automatic drive_cycle(input logic v, input dual_issue_backend_pkg::issue_pair_t p,
                               input logic hold, input logic fl);
        @(negedge clk);
        check_outputs();
        id_valid = v;
        id_pair  = p;
        ex_hold  = hold;
        flush    = fl;
    endtask

    task automatic drain();
        repeat (2) drive_cycle(1'b0, '0, 1'b0, 1'b0);
        while (rr_full || (expect_q.size() > 0)) begin
            drive_cycle(1'b0, '0, 1'b0, 1'b0);
        end
        drive_cycle(1'b0, '0, 1'b0, 1'b0);
    endtask

    function automatic int unsigned rnd(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic dual_issue_backend_pkg::slot_t rand_slot(input int exc_pct);
        dual_issue_backend_pkg::slot_t s;
        logic [31:0] r;
        r          = $random(seed);
        s.valid    = (r[2:0] != 3'd0);
        s.pc       = next_pc;
        s.inst     = $random(seed);
        s.uop      = dual_issue_backend_pkg::alu_op_e'(r[6:3] % 4'd10);
        s.use_imm  = r[7] || (s.uop == dual_issue_backend_pkg::OP_LUI);
        s.imm      = $random(seed);
        s.rj       = {2'b00, r[10:8]};
        s.rk       = {2'b00, r[13:11]};
        s.rd       = {2'b00, r[16:14]};
        s.we       = (r[19:17] != 3'd0);
        s.is_syscall = 1'b0;
        s.is_break   = 1'b0;
        s.is_priv    = 1'b0;
        if (($unsigned(r[26:20]) % 100) < exc_pct) begin
            s.is_syscall = r[27];
            s.is_break   = r[28];
            s.is_priv    = r[29] || !(r[27] || r[28]);
        end
        next_pc = next_pc + 4;
        return s;
    endfunction

    // mode 0 keeps slot 1 off slot 0's destination, mode 1 chains the slots and the pairs
    function automatic dual_issue_backend_pkg::issue_pair_t gen_pair(input int mode,
                                                                     input int exc_pct);
        dual_issue_backend_pkg::issue_pair_t p;
        p.slot0 = rand_slot(exc_pct);
        p.slot1 = rand_slot(exc_pct);
        if (mode == 0) begin
            if (p.slot1.rj == p.slot0.rd) p.slot1.rj = '0;
            if (p.slot1.rk == p.slot0.rd) p.slot1.rk = '0;
        end else if (mode == 1) begin
            p.slot0.rj = last_rd;
            p.slot1.rj = p.slot0.rd;
            if (rnd(2) == 0) p.slot1.rk = p.slot0.rd;
            if (rnd(4) == 0) p.slot1.rd = p.slot0.rd;
        end
        last_rd = p.slot1.rd;
        return p;
    endfunction

    task automatic report_test(input int id, input string name, input int start);
        if (err_count == start) begin
            $display("test %0d %s: ok", id, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", id, name, err_count - start);
        end
    endtask

    task automatic run_basic();
        dual_issue_backend_pkg::issue_pair_t p;
        int start;
        start = err_count;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        // reset values of commit and id_ready
        check_outputs();
        arst_n = 1'b1;
        repeat (4) drive_cycle(1'b0, '0, 1'b0, 1'b0);
        // or rd, rd, r0 reads every register back from its reset value
        for (int r = 1; r < `DIB_NREGS; r += 2) begin
            p               = '0;
            p.slot0.valid   = 1'b1;
            p.slot0.pc      = next_pc;
            p.slot0.uop     = dual_issue_backend_pkg::OP_OR;
            p.slot0.we      = 1'b1;
            p.slot0.rj      = r[`DIB_REG_AW-1:0];
            p.slot0.rd      = r[`DIB_REG_AW-1:0];
            p.slot1         = p.slot0;
            p.slot1.pc      = next_pc + 4;
            p.slot1.rj      = r[`DIB_REG_AW-1:0] + 1'b1;
            p.slot1.rd      = r[`DIB_REG_AW-1:0] + 1'b1;
            next_pc         = next_pc + 8;
            drive_cycle(1'b1, p, 1'b0, 1'b0);
        end
        drain();
        report_test(1, "reset state", start);
    endtask

    task automatic run_random(input int id, input string name, input int mode,
                              input int exc_pct, input int hold_pct, input int flush_pct,
                              input int idle_pct);
        int start;
        start = err_count;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            drive_cycle(rnd(100) >= idle_pct, gen_pair(mode, exc_pct),
                        rnd(100) < hold_pct, rnd(100) < flush_pct);
        end
        drain();
        report_test(id, name, start);
    endtask

    initial begin
        seed        = 32'h1859_f36c;
        err_count   = 0;
        check_count = 0;
        cycle_count = 0;
        last_rd     = '0;
        next_pc     = 32'h1c00_0000;
        arst_n      = 1'b0;
        flush       = 1'b0;
        ex_hold     = 1'b0;
        id_valid    = 1'b0;
        id_pair     = '0;
        run_basic();
        run_random(2, "independent pairs", 0, 0, 0, 0, 10);
        run_random(3, "dependent streams", 1, 0, 0, 0, 15);
        run_random(4, "random hold", 2, 0, 40, 0, 20);
        run_random(5, "flush", 2, 0, 30, 25, 15);
        run_random(6, "exceptions", 1, 40, 10, 0, 10);
        $display("6 tests, %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* dual_issue_backend.f */
+incdir+include
rtl/dual_issue_backend_pkg.sv
rtl/regfile.sv
rtl/reg_read_stage.sv
rtl/operand_bypass.sv
rtl/alu.sv
rtl/execute_stage.sv
rtl/dual_issue_backend.sv
dv/dual_issue_backend_tb.sv
